// ==== design/cpu_decode.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpu_macros.svh"

module cpu_decode import cpu_pkg::*; (
	input  logic                 clk,
	input  logic                 i_rst_n,
	input  logic [`CPU_XLEN-1:0] i_instr,
	input  logic                 i_fetched,
	input  logic [`CPU_XLEN-1:0] i_pc_plus_4,
	output logic [REG_SEL_W-1:0] o_ra_sel,
	output logic [REG_SEL_W-1:0] o_rb_sel,
	cpu_de_if.src                de
);

	opcode_e opcode;
	simm16_t imm16;
	logic signed [`CPU_XLEN-1:0] imm32;
	alu_op_e alu_op;
	logic update_rd;
	logic use_imm;
	logic mem_load;
	logic mem_store;
	logic is_branch;
	logic branch_ne;
	logic useful;

	assign opcode = opcode_e'(i_instr[OPC_LSB +: OPC_W]);
	assign o_ra_sel = i_instr[RA_LSB +: REG_SEL_W];
	assign o_rb_sel = i_instr[RB_LSB +: REG_SEL_W];
	assign imm16 = simm16_t'(i_instr[IMM_LSB +: IMM_W]);
	assign imm32 = imm16;

	always_comb begin
		alu_op = ALU_PASS_B;
		update_rd = 1'b0;
		use_imm = 1'b0;
		mem_load = 1'b0;
		mem_store = 1'b0;
		is_branch = 1'b0;
		branch_ne = 1'b0;
		useful = 1'b1;
		case (opcode)
		OP_ADD: begin
			alu_op = ALU_ADD;
			update_rd = 1'b1;
		end
		OP_SUB: begin
			alu_op = ALU_SUB;
			update_rd = 1'b1;
		end
		OP_AND: begin
			alu_op = ALU_AND;
			update_rd = 1'b1;
		end
		OP_OR: begin
			alu_op = ALU_OR;
			update_rd = 1'b1;
		end
		OP_XOR: begin
			alu_op = ALU_XOR;
			update_rd = 1'b1;
		end
		OP_ADDI: begin
			alu_op = ALU_ADD;
			update_rd = 1'b1;
			use_imm = 1'b1;
		end
		// loads and stores use the ALU for ra + imm
		OP_LDW: begin
			alu_op = ALU_ADD;
			update_rd = 1'b1;
			use_imm = 1'b1;
			mem_load = 1'b1;
		end
		OP_STW: begin
			alu_op = ALU_ADD;
			use_imm = 1'b1;
			mem_store = 1'b1;
		end
		OP_BEQ: is_branch = 1'b1;
		OP_BNE: begin
			is_branch = 1'b1;
			branch_ne = 1'b1;
		end
		// NOP and HALT have nothing left to do past fetch
		default: useful = 1'b0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!i_rst_n)
			de.valid <= 1'b0;
		else
			de.valid <= i_fetched && useful;
	end

	always_ff @(posedge clk) begin
		de.alu_op <= alu_op;
		de.rd <= i_instr[RD_LSB +: REG_SEL_W];
		de.update_rd <= update_rd;
		de.imm32 <= imm32;
		de.use_imm <= use_imm;
		de.pc_plus_4 <= i_pc_plus_4;
		de.mem_load <= mem_load;
		de.mem_store <= mem_store;
		de.is_branch <= is_branch;
		de.branch_ne <= branch_ne;
	end

endmodule

`default_nettype wire

// ==== design/cpu_exec.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpu_macros.svh"

module cpu_exec import cpu_pkg::*; (
	input  logic                 clk,
	input  logic                 i_rst_n,
	input  logic [`CPU_XLEN-1:0] i_ra,
	input  logic [`CPU_XLEN-1:0] i_rb,
	cpu_de_if.dst                de,
	cpu_em_if.src                em,
	output logic                 o_branch_taken,
	output logic [`CPU_XLEN-1:0] o_branch_pc,
	output logic                 o_stall_clear
);

	logic [`CPU_XLEN-1:0] op_b;
	logic [`CPU_XLEN-1:0] alu_out;
	logic equal;

	assign op_b = de.use_imm ? de.imm32 : i_rb;

	always_comb begin
		case (de.alu_op)
		ALU_ADD: alu_out = i_ra + op_b;
		ALU_SUB: alu_out = i_ra - op_b;
		ALU_AND: alu_out = i_ra & op_b;
		ALU_OR: alu_out = i_ra | op_b;
		ALU_XOR: alu_out = i_ra ^ op_b;
		ALU_PASS_B: alu_out = op_b;
		default: alu_out = op_b;
		endcase
	end

	// branches resolve here and release the fetch that has waited since the opcode
	assign equal = (i_ra == i_rb);
	assign o_stall_clear = de.valid && de.is_branch;
	assign o_branch_taken = o_stall_clear && (de.branch_ne ? !equal : equal);
	assign o_branch_pc = de.pc_plus_4 + {de.imm32[`CPU_XLEN-3:0], 2'b00};

	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			em.valid <= 1'b0;
			em.update_rd <= 1'b0;
			em.mem_load <= 1'b0;
			em.mem_store <= 1'b0;
		end else begin
			em.valid <= de.valid;
			em.update_rd <= de.valid && de.update_rd;
			em.mem_load <= de.valid && de.mem_load;
			em.mem_store <= de.valid && de.mem_store;
		end
	end

	always_ff @(posedge clk) begin
		em.alu_out <= alu_out;
		em.store_val <= i_rb;
		em.rd <= de.rd;
	end

endmodule

`default_nettype wire

// ==== design/cpu_fetch.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpu_macros.svh"

module cpu_fetch import cpu_pkg::*; (
	input  logic                 clk,
	input  logic                 i_rst_n,
	input  logic                 i_run,
	output logic                 o_i_access,
	output logic [`CPU_AW-1:0]   o_i_addr,
	input  logic [`CPU_XLEN-1:0] i_i_data,
	input  logic                 i_i_ack,
	input  logic                 i_stall_clear,
	input  logic                 i_branch_taken,
	input  logic [`CPU_XLEN-1:0] i_branch_pc,
	input  logic                 i_complete,
	input  logic                 i_pipe_busy,
	output logic [`CPU_XLEN-1:0] o_instr,
	output logic [`CPU_XLEN-1:0] o_pc_plus_4,
	output logic                 o_fetched,
	output logic                 o_stopped,
	output logic [`CPU_XLEN-1:0] o_dbg_pc,
	input  logic                 i_dbg_pc_wr_en,
	input  logic [`CPU_XLEN-1:0] i_dbg_pc_wr_val
);

	typedef enum logic [1:0] {F_IDLE, F_REQUEST, F_STALLED} fetch_state_e;

	fetch_state_e state;
	logic [`CPU_XLEN-1:0] pc;
	logic halted;
	logic issuing;
	opcode_e fetched_op;

	assign issuing = i_run && !halted;
	assign fetched_op = opcode_e'(i_i_data[OPC_LSB +: OPC_W]);

	assign o_i_access = (state == F_REQUEST);
	assign o_i_addr = pc[`CPU_XLEN-1:2];
	assign o_instr = i_i_data;
	assign o_fetched = o_i_access && i_i_ack;
	assign o_pc_plus_4 = pc + `CPU_XLEN'd4;
	assign o_stopped = (state == F_IDLE) && !issuing && !i_pipe_busy;
	assign o_dbg_pc = pc;

	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			state <= F_IDLE;
			pc <= '0;
			halted <= 1'b0;
		end else begin
			case (state)
			F_IDLE: begin
				if (o_stopped && i_dbg_pc_wr_en) begin
					pc <= i_dbg_pc_wr_val;
					halted <= 1'b0;
				end else if (issuing) begin
					state <= F_REQUEST;
				end
			end
			F_REQUEST: begin
				if (i_i_ack) begin
					pc <= o_pc_plus_4;
					// anything that changes flow or touches memory waits to resolve
					case (fetched_op)
					OP_BEQ, OP_BNE, OP_LDW, OP_STW: state <= F_STALLED;
					OP_HALT: begin
						halted <= 1'b1;
						state <= F_IDLE;
					end
					default: state <= F_IDLE;
					endcase
				end
			end
			F_STALLED: begin
				if (i_stall_clear || i_complete) begin
					state <= issuing ? F_REQUEST : F_IDLE;
					if (i_branch_taken)
						pc <= i_branch_pc;
				end
			end
			default: state <= F_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== design/cpu_macros.svh ====
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// data path and instruction width
`define CPU_XLEN 32

// number of architectural registers including r0 which reads as zero
`define CPU_NREGS 16

// bus addresses count 32-bit words
`define CPU_AW 30

`endif

// ==== design/cpu_memory.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpu_macros.svh"

module cpu_memory import cpu_pkg::*; (
	input  logic                 clk,
	input  logic                 i_rst_n,
	cpu_em_if.dst                em,
	output logic                 o_d_access,
	output logic [`CPU_AW-1:0]   o_d_addr,
	output logic                 o_d_wr_en,
	output logic [`CPU_XLEN-1:0] o_d_wr_val,
	input  logic [`CPU_XLEN-1:0] i_d_data,
	input  logic                 i_d_ack,
	output logic                 o_wb_en,
	output logic [REG_SEL_W-1:0] o_wb_rd,
	output logic [`CPU_XLEN-1:0] o_wb_val,
	output logic                 o_complete,
	output logic                 o_busy
);

	logic mem_op;
	logic load_wb;

	assign mem_op = em.valid && (em.mem_load || em.mem_store);
	assign o_busy = o_d_access;

	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			o_d_access <= 1'b0;
			o_d_wr_en <= 1'b0;
			o_wb_en <= 1'b0;
			o_complete <= 1'b0;
		end else begin
			o_wb_en <= 1'b0;
			o_complete <= 1'b0;
			if (o_d_access) begin
				if (i_d_ack) begin
					o_d_access <= 1'b0;
					o_d_wr_en <= 1'b0;
					o_wb_en <= load_wb;
					o_complete <= 1'b1;
				end
			end else if (mem_op) begin
				o_d_access <= 1'b1;
				o_d_wr_en <= em.mem_store;
			end else if (em.valid) begin
				o_wb_en <= em.update_rd;
			end
		end
	end

	// the execute bundle moves on, so the access keeps its own copy
	always_ff @(posedge clk) begin
		if (!o_d_access) begin
			o_wb_rd <= em.rd;
			o_wb_val <= em.alu_out;
			if (mem_op) begin
				o_d_addr <= em.alu_out[`CPU_XLEN-1:2];
				o_d_wr_val <= em.store_val;
				load_wb <= em.mem_load && em.update_rd;
			end
		end else if (i_d_ack) begin
			o_wb_val <= i_d_data;
		end
	end

endmodule

`default_nettype wire

// ==== design/cpu_pipeline.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpu_macros.svh"

module cpu_pipeline import cpu_pkg::*; (
	input  logic                 clk,
	input  logic                 i_rst_n,
	input  logic                 i_run,
	output logic                 o_stopped,
	output logic                 o_i_access,
	output logic [`CPU_AW-1:0]   o_i_addr,
	input  logic [`CPU_XLEN-1:0] i_i_data,
	input  logic                 i_i_ack,
	output logic                 o_d_access,
	output logic [`CPU_AW-1:0]   o_d_addr,
	output logic                 o_d_wr_en,
	output logic [`CPU_XLEN-1:0] o_d_wr_val,
	input  logic [`CPU_XLEN-1:0] i_d_data,
	input  logic                 i_d_ack,
	input  logic [REG_SEL_W-1:0] i_dbg_reg_sel,
	input  logic                 i_dbg_reg_wr_en,
	input  logic [`CPU_XLEN-1:0] i_dbg_reg_wr_val,
	output logic [`CPU_XLEN-1:0] o_dbg_reg_val,
	output logic [`CPU_XLEN-1:0] o_dbg_pc,
	input  logic                 i_dbg_pc_wr_en,
	input  logic [`CPU_XLEN-1:0] i_dbg_pc_wr_val
);

	logic [`CPU_XLEN-1:0] fd_instr;
	logic [`CPU_XLEN-1:0] fd_pc_plus_4;
	logic fd_fetched;
	logic ef_branch_taken;
	logic [`CPU_XLEN-1:0] ef_branch_pc;
	logic ef_stall_clear;
	logic mf_complete;
	logic m_busy;
	logic wb_en;
	logic [REG_SEL_W-1:0] wb_rd;
	logic [`CPU_XLEN-1:0] wb_val;
	logic [REG_SEL_W-1:0] d_ra_sel;
	logic [REG_SEL_W-1:0] d_rb_sel;
	logic [REG_SEL_W-1:0] e_ra_sel;
	logic [REG_SEL_W-1:0] e_rb_sel;
	logic [`CPU_XLEN-1:0] rf_ra;
	logic [`CPU_XLEN-1:0] rf_rb;
	logic [`CPU_XLEN-1:0] ex_ra;
	logic [`CPU_XLEN-1:0] ex_rb;
	logic pipe_busy;

	cpu_de_if de_bus ();
	cpu_em_if em_bus ();

	assign pipe_busy = fd_fetched || de_bus.valid || em_bus.valid || m_busy || wb_en;

	cpu_fetch u_fetch (
		.clk(clk),
		.i_rst_n(i_rst_n),
		.i_run(i_run),
		.o_i_access(o_i_access),
		.o_i_addr(o_i_addr),
		.i_i_data(i_i_data),
		.i_i_ack(i_i_ack),
		.i_stall_clear(ef_stall_clear),
		.i_branch_taken(ef_branch_taken),
		.i_branch_pc(ef_branch_pc),
		.i_complete(mf_complete),
		.i_pipe_busy(pipe_busy),
		.o_instr(fd_instr),
		.o_pc_plus_4(fd_pc_plus_4),
		.o_fetched(fd_fetched),
		.o_stopped(o_stopped),
		.o_dbg_pc(o_dbg_pc),
		.i_dbg_pc_wr_en(i_dbg_pc_wr_en),
		.i_dbg_pc_wr_val(i_dbg_pc_wr_val)
	);

	cpu_decode u_decode (
		.clk(clk),
		.i_rst_n(i_rst_n),
		.i_instr(fd_instr),
		.i_fetched(fd_fetched),
		.i_pc_plus_4(fd_pc_plus_4),
		.o_ra_sel(d_ra_sel),
		.o_rb_sel(d_rb_sel),
		.de(de_bus)
	);

	cpu_exec u_exec (
		.clk(clk),
		.i_rst_n(i_rst_n),
		.i_ra(ex_ra),
		.i_rb(ex_rb),
		.de(de_bus),
		.em(em_bus),
		.o_branch_taken(ef_branch_taken),
		.o_branch_pc(ef_branch_pc),
		.o_stall_clear(ef_stall_clear)
	);

	cpu_memory u_memory (
		.clk(clk),
		.i_rst_n(i_rst_n),
		.em(em_bus),
		.o_d_access(o_d_access),
		.o_d_addr(o_d_addr),
		.o_d_wr_en(o_d_wr_en),
		.o_d_wr_val(o_d_wr_val),
		.i_d_data(i_d_data),
		.i_d_ack(i_d_ack),
		.o_wb_en(wb_en),
		.o_wb_rd(wb_rd),
		.o_wb_val(wb_val),
		.o_complete(mf_complete),
		.o_busy(m_busy)
	);

	cpu_regfile u_regfile (
		.clk(clk),
		.i_rst_n(i_rst_n),
		.i_ra_sel(e_ra_sel),
		.i_rb_sel(e_rb_sel),
		.o_ra(rf_ra),
		.o_rb(rf_rb),
		.i_wr_en(wb_en),
		.i_rd_sel(wb_rd),
		.i_wr_val(wb_val),
		.i_dbg_en(o_stopped),
		.i_dbg_sel(i_dbg_reg_sel),
		.i_dbg_wr_en(i_dbg_reg_wr_en),
		.i_dbg_wr_val(i_dbg_reg_wr_val),
		.o_dbg_val(o_dbg_reg_val)
	);

	// operand selects follow their instruction into execute
	always_ff @(posedge clk) begin
		e_ra_sel <= d_ra_sel;
		e_rb_sel <= d_rb_sel;
	end

	// newest producer wins; a load's ALU output is only its address
	function automatic logic [`CPU_XLEN-1:0] forward(input logic [REG_SEL_W-1:0] sel,
			input logic [`CPU_XLEN-1:0] rf_val);
		if (sel == '0)
			return '0;
		if (em_bus.update_rd && !em_bus.mem_load && em_bus.rd == sel)
			return em_bus.alu_out;
		if (wb_en && wb_rd == sel)
			return wb_val;
		return rf_val;
	endfunction

	always_comb begin
		ex_ra = forward(e_ra_sel, rf_ra);
		ex_rb = forward(e_rb_sel, rf_rb);
	end

endmodule

`default_nettype wire

// ==== design/cpu_pkg.sv ====
`default_nettype none
`include "cpu_macros.svh"

package cpu_pkg;

	localparam int REG_SEL_W = $clog2(`CPU_NREGS);

	// the instruction holds opcode, rd, ra, rb and imm16 from the top down
	localparam int OPC_LSB = 28;
	localparam int OPC_W = 4;
	localparam int RD_LSB = 24;
	localparam int RA_LSB = 20;
	localparam int RB_LSB = 16;
	localparam int IMM_LSB = 0;
	localparam int IMM_W = 16;

	typedef enum logic [OPC_W-1:0] {
		OP_NOP  = 4'h0,
		OP_ADD  = 4'h1,
		OP_SUB  = 4'h2,
		OP_AND  = 4'h3,
		OP_OR   = 4'h4,
		OP_XOR  = 4'h5,
		OP_ADDI = 4'h6,
		OP_LDW  = 4'h7,
		OP_STW  = 4'h8,
		OP_BEQ  = 4'h9,
		OP_BNE  = 4'ha,
		OP_HALT = 4'hf
	} opcode_e;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_PASS_B
	} alu_op_e;

	// signed so that widening it sign-extends
	typedef logic signed [IMM_W-1:0] simm16_t;

endpackage

`default_nettype wire

// ==== design/cpu_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpu_macros.svh"

module cpu_regfile import cpu_pkg::*; (
	input  logic                 clk,
	input  logic                 i_rst_n,
	input  logic [REG_SEL_W-1:0] i_ra_sel,
	input  logic [REG_SEL_W-1:0] i_rb_sel,
	output logic [`CPU_XLEN-1:0] o_ra,
	output logic [`CPU_XLEN-1:0] o_rb,
	input  logic                 i_wr_en,
	input  logic [REG_SEL_W-1:0] i_rd_sel,
	input  logic [`CPU_XLEN-1:0] i_wr_val,
	input  logic                 i_dbg_en,
	input  logic [REG_SEL_W-1:0] i_dbg_sel,
	input  logic                 i_dbg_wr_en,
	input  logic [`CPU_XLEN-1:0] i_dbg_wr_val,
	output logic [`CPU_XLEN-1:0] o_dbg_val
);

	logic [`CPU_XLEN-1:0] regs [`CPU_NREGS];

	assign o_ra = (i_ra_sel == '0) ? '0 : regs[i_ra_sel];
	assign o_rb = (i_rb_sel == '0) ? '0 : regs[i_rb_sel];
	assign o_dbg_val = (i_dbg_sel == '0) ? '0 : regs[i_dbg_sel];

	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			for (int i = 0; i < `CPU_NREGS; i++)
				regs[i] <= '0;
		end else if (i_wr_en && i_rd_sel != '0) begin
			regs[i_rd_sel] <= i_wr_val;
		end else if (i_dbg_en && i_dbg_wr_en && i_dbg_sel != '0) begin
			regs[i_dbg_sel] <= i_dbg_wr_val;
		end
	end

endmodule

`default_nettype wire

// ==== design/cpu_stage_if.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpu_macros.svh"

interface cpu_de_if import cpu_pkg::*; ();
	logic valid;
	alu_op_e alu_op;
	logic [REG_SEL_W-1:0] rd;
	logic update_rd;
	logic [`CPU_XLEN-1:0] imm32;
	logic use_imm;
	logic [`CPU_XLEN-1:0] pc_plus_4;
	logic mem_load;
	logic mem_store;
	logic is_branch;
	logic branch_ne;

	modport src (output valid, alu_op, rd, update_rd, imm32, use_imm, pc_plus_4,
		mem_load, mem_store, is_branch, branch_ne);
	modport dst (input valid, alu_op, rd, update_rd, imm32, use_imm, pc_plus_4,
		mem_load, mem_store, is_branch, branch_ne);
endinterface

interface cpu_em_if import cpu_pkg::*; ();
	logic valid;
	logic [`CPU_XLEN-1:0] alu_out;
	logic [`CPU_XLEN-1:0] store_val;
	logic [REG_SEL_W-1:0] rd;
	logic update_rd;
	logic mem_load;
	logic mem_store;

	modport src (output valid, alu_out, store_val, rd, update_rd, mem_load, mem_store);
	modport dst (input valid, alu_out, store_val, rd, update_rd, mem_load, mem_store);
endinterface

`default_nettype wire

// ==== filelist.f ====
+incdir+design
design/cpu_pkg.sv
design/cpu_stage_if.sv
design/cpu_fetch.sv
design/cpu_decode.sv
design/cpu_exec.sv
design/cpu_memory.sv
design/cpu_regfile.sv
design/cpu_pipeline.sv
verif/cpu_pipeline_asserts.sv
verif/cpu_pipeline_tb.sv

// ==== verif/cpu_pipeline_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpu_macros.svh"

module cpu_pipeline_asserts (
	input logic                 clk,
	input logic                 i_rst_n,
	input logic                 o_stopped,
	input logic                 o_i_access,
	input logic [`CPU_AW-1:0]   o_i_addr,
	input logic                 i_i_ack,
	input logic                 o_d_access,
	input logic [`CPU_AW-1:0]   o_d_addr,
	input logic                 o_d_wr_en,
	input logic [`CPU_XLEN-1:0] o_d_wr_val,
	input logic                 i_d_ack
);

	a_reset_idle: assert property (@(posedge clk)
		!i_rst_n |=> !o_i_access && !o_d_access && !o_d_wr_en)
		else $error("bus access open right after reset");

	// a held request keeps its address until the ack
	a_i_hold: assert property (@(posedge clk) disable iff (!i_rst_n)
		o_i_access && !i_i_ack |=> o_i_access && $stable(o_i_addr))
		else $error("instruction request changed before its ack");

	a_d_hold: assert property (@(posedge clk) disable iff (!i_rst_n)
		o_d_access && !i_d_ack |=> o_d_access && $stable(o_d_addr)
			&& $stable(o_d_wr_en) && $stable(o_d_wr_val))
		else $error("data request changed before its ack");

	a_i_drop: assert property (@(posedge clk) disable iff (!i_rst_n)
		o_i_access && i_i_ack |=> !o_i_access)
		else $error("instruction access still open after its ack");

	a_d_drop: assert property (@(posedge clk) disable iff (!i_rst_n)
		o_d_access && i_d_ack |=> !o_d_access)
		else $error("data access still open after its ack");

	a_stopped_quiet: assert property (@(posedge clk) disable iff (!i_rst_n)
		o_stopped |-> !o_i_access && !o_d_access)
		else $error("bus access open while the core reports stopped");

endmodule

`default_nettype wire

// ==== verif/cpu_pipeline_tb.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpu_macros.svh"

module cpu_pipeline_tb import cpu_pkg::*; ();

	// about 120 instructions at well under 20 cycles each plus the debug reads
	localparam int MAX_CYCLES = 20000;

	logic clk;
	logic i_rst_n;
	logic i_run;
	logic o_stopped;
	logic o_i_access;
	logic [`CPU_AW-1:0] o_i_addr;
	logic [`CPU_XLEN-1:0] i_i_data;
	logic i_i_ack;
	logic o_d_access;
	logic [`CPU_AW-1:0] o_d_addr;
	logic o_d_wr_en;
	logic [`CPU_XLEN-1:0] o_d_wr_val;
	logic [`CPU_XLEN-1:0] i_d_data;
	logic i_d_ack;
	logic [REG_SEL_W-1:0] i_dbg_reg_sel;
	logic i_dbg_reg_wr_en;
	logic [`CPU_XLEN-1:0] i_dbg_reg_wr_val;
	logic [`CPU_XLEN-1:0] o_dbg_reg_val;
	logic [`CPU_XLEN-1:0] o_dbg_pc;
	logic i_dbg_pc_wr_en;
	logic [`CPU_XLEN-1:0] i_dbg_pc_wr_val;

	logic [31:0] imem [256];
	logic [31:0] dmem [256];
	logic [31:0] ref_dmem [256];
	logic [31:0] ref_regs [`CPU_NREGS];
	logic [31:0] ref_pc;
	logic [29:0] ref_st_addr [$];
	logic [31:0] ref_st_val [$];
	logic [29:0] log_st_addr [$];
	logic [31:0] log_st_val [$];
	integer seed = 32'h3dae;
	int error_count;
	int check_count;
	int fetch_count;
	int cycle_count;

	cpu_pipeline i_dut (.*);

	bind cpu_pipeline cpu_pipeline_asserts u_asserts (
		.clk(clk),
		.i_rst_n(i_rst_n),
		.o_stopped(o_stopped),
		.o_i_access(o_i_access),
		.o_i_addr(o_i_addr),
		.i_i_ack(i_i_ack),
		.o_d_access(o_d_access),
		.o_d_addr(o_d_addr),
		.o_d_wr_en(o_d_wr_en),
		.o_d_wr_val(o_d_wr_val),
		.i_d_ack(i_d_ack)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic next_cycle();
		@(posedge clk);
		#2;
	endtask

	function automatic logic [31:0] enc(input logic [3:0] op, input logic [3:0] rd,
			input logic [3:0] ra, input logic [3:0] rb, input logic [15:0] imm);
		return (32'(op) << OPC_LSB) | (32'(rd) << RD_LSB) | (32'(ra) << RA_LSB)
			| (32'(rb) << RB_LSB) | (32'(imm) << IMM_LSB);
	endfunction

	function automatic void write_ref(input logic [3:0] rd, input logic [31:0] val);
		if (rd != 4'd0)
			ref_regs[rd] = val;
	endfunction

	// ISA model that runs from start_pc until HALT
	function automatic void exec_program(input logic [31:0] start_pc);
		logic [31:0] pc;
		logic [31:0] ir;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] imm;
		logic [31:0] addr;
		logic [3:0] rd;
		int steps;
		bit done;
		pc = start_pc;
		done = 1'b0;
		steps = 0;
		while (!done && steps < 4000) begin
			ir = imem[pc[9:2]];
			rd = ir[RD_LSB +: 4];
			a = ref_regs[ir[RA_LSB +: 4]];
			b = ref_regs[ir[RB_LSB +: 4]];
			imm = {{16{ir[IMM_LSB + IMM_W - 1]}}, ir[IMM_LSB +: IMM_W]};
			addr = a + imm;
			pc = pc + 32'd4;
			steps++;
			case (ir[OPC_LSB +: OPC_W])
			OP_ADD: write_ref(rd, a + b);
			OP_SUB: write_ref(rd, a - b);
			OP_AND: write_ref(rd, a & b);
			OP_OR: write_ref(rd, a | b);
			OP_XOR: write_ref(rd, a ^ b);
			OP_ADDI: write_ref(rd, addr);
			OP_LDW: write_ref(rd, ref_dmem[addr[9:2]]);
			OP_STW: begin
				ref_dmem[addr[9:2]] = b;
				ref_st_addr.push_back(addr[31:2]);
				ref_st_val.push_back(b);
			end
			// branch offsets count words from the next instruction
			OP_BEQ: if (a == b) pc = pc + (imm << 2);
			OP_BNE: if (a != b) pc = pc + (imm << 2);
			OP_HALT: done = 1'b1;
			default: ;
			endcase
		end
		ref_pc = pc;
	endfunction

	task automatic gen_random_program(input int base, input int count);
		logic [3:0] ops [8];
		logic [31:0] r;
		ops = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_ADDI, OP_LDW, OP_STW};
		for (int n = 0; n < count; n++) begin
			r = $random(seed);
			// memory ops stay in the first 64 data words
			if (ops[r[2:0]] == OP_LDW || ops[r[2:0]] == OP_STW)
				imem[base + n] = enc(ops[r[2:0]], r[7:4], 4'd0, r[11:8], {8'h00, r[21:16], 2'b00});
			else
				imem[base + n] = enc(ops[r[2:0]], r[7:4], r[11:8], r[15:12], r[31:16]);
		end
		imem[base + count] = enc(OP_HALT, 0, 0, 0, 0);
	endtask

	task automatic load_programs();
		for (int i = 0; i < 256; i++) begin
			imem[i] = enc(OP_HALT, 0, 0, 0, 16'(i));
			dmem[i] = 32'(i) * 32'h0100_0193 + 32'h6a09_e667;
			ref_dmem[i] = dmem[i];
		end
		for (int i = 0; i < `CPU_NREGS; i++)
			ref_regs[i] = '0;
		// results used 1, 2 and 3 instructions later
		imem[0] = enc(OP_ADDI, 1, 0, 0, 5);
		imem[1] = enc(OP_ADDI, 2, 1, 0, 7);
		imem[2] = enc(OP_ADD, 3, 1, 2, 0);
		imem[3] = enc(OP_SUB, 4, 3, 1, 0);
		imem[4] = enc(OP_XOR, 5, 4, 2, 0);
		imem[5] = enc(OP_ADDI, 6, 0, 0, -1);
		imem[6] = enc(OP_AND, 7, 6, 5, 0);
		imem[7] = enc(OP_OR, 8, 7, 3, 0);
		imem[8] = enc(OP_ADD, 9, 8, 8, 0);
		imem[9] = enc(OP_ADDI, 0, 9, 0, 3);
		imem[10] = enc(OP_ADD, 10, 0, 9, 0);
		imem[11] = enc(OP_HALT, 0, 0, 0, 0);
		imem[32] = enc(OP_ADDI, 1, 0, 0, 16'h0040);
		imem[33] = enc(OP_ADDI, 2, 0, 0, 16'h1234);
		imem[34] = enc(OP_STW, 0, 1, 2, 0);
		imem[35] = enc(OP_ADDI, 3, 2, 0, 1);
		imem[36] = enc(OP_STW, 0, 1, 3, 4);
		imem[37] = enc(OP_LDW, 4, 1, 0, 0);
		imem[38] = enc(OP_ADD, 5, 4, 3, 0);
		imem[39] = enc(OP_LDW, 6, 1, 0, 4);
		imem[40] = enc(OP_SUB, 7, 6, 4, 0);
		imem[41] = enc(OP_STW, 0, 1, 7, 8);
		imem[42] = enc(OP_LDW, 8, 1, 0, 8);
		imem[43] = enc(OP_LDW, 9, 1, 0, 12);
		imem[44] = enc(OP_XOR, 10, 9, 8, 0);
		imem[45] = enc(OP_HALT, 0, 0, 0, 0);
		// counted loop with a backward BNE followed by forward branches both ways
		imem[64] = enc(OP_ADDI, 1, 0, 0, 4);
		imem[65] = enc(OP_ADDI, 2, 0, 0, 0);
		imem[66] = enc(OP_ADD, 2, 2, 1, 0);
		imem[67] = enc(OP_ADDI, 1, 1, 0, -1);
		imem[68] = enc(OP_BNE, 0, 1, 0, -3);
		imem[69] = enc(OP_BEQ, 0, 2, 0, 2);
		imem[70] = enc(OP_BEQ, 0, 1, 0, 1);
		imem[71] = enc(OP_ADDI, 3, 0, 0, 99);
		imem[72] = enc(OP_ADDI, 4, 0, 0, 7);
		imem[73] = enc(OP_BNE, 0, 4, 4, 1);
		imem[74] = enc(OP_ADDI, 5, 4, 0, 1);
		imem[75] = enc(OP_HALT, 0, 0, 0, 0);
		// starts from registers written over the debug port
		imem[96] = enc(OP_ADD, 13, 11, 12, 0);
		imem[97] = enc(OP_STW, 0, 12, 13, 0);
		imem[98] = enc(OP_LDW, 14, 12, 0, 0);
		imem[99] = enc(OP_SUB, 15, 14, 11, 0);
		imem[100] = enc(OP_OR, 1, 0, 11, 0);
		imem[101] = enc(OP_HALT, 0, 0, 0, 0);
		gen_random_program(128, 60);
	endtask

	initial begin : instr_mem
		int wait_left;
		wait_left = -1;
		forever begin
			next_cycle();
			if (i_i_ack) begin
				i_i_ack = 1'b0;
			end else if (o_i_access) begin
				if (wait_left < 0)
					wait_left = $unsigned($random(seed)) % 4;
				if (wait_left == 0) begin
					i_i_data = imem[o_i_addr[7:0]];
					i_i_ack = 1'b1;
					fetch_count++;
				end
				wait_left--;
			end
		end
	end

	initial begin : data_mem
		int wait_left;
		wait_left = -1;
		forever begin
			next_cycle();
			if (i_d_ack) begin
				i_d_ack = 1'b0;
			end else if (o_d_access) begin
				if (wait_left < 0)
					wait_left = $unsigned($random(seed)) % 4;
				if (wait_left == 0) begin
					if (o_d_wr_en) begin
						dmem[o_d_addr[7:0]] = o_d_wr_val;
						log_st_addr.push_back(o_d_addr);
						log_st_val.push_back(o_d_wr_val);
					end else begin
						i_d_data = dmem[o_d_addr[7:0]];
					end
					i_d_ack = 1'b1;
				end
				wait_left--;
			end
		end
	end

	task automatic check_word(input string what, input logic [31:0] got,
			input logic [31:0] exp);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic debug_write(input int r, input logic [31:0] val);
		next_cycle();
		i_dbg_reg_sel = REG_SEL_W'(r);
		i_dbg_reg_wr_en = 1'b1;
		i_dbg_reg_wr_val = val;
		next_cycle();
		i_dbg_reg_wr_en = 1'b0;
		write_ref(4'(r), val);
	endtask

	task automatic run_program(input logic [31:0] start_pc);
		int fetched;
		ref_st_addr.delete();
		ref_st_val.delete();
		log_st_addr.delete();
		log_st_val.delete();
		exec_program(start_pc);
		next_cycle();
		i_dbg_pc_wr_en = 1'b1;
		i_dbg_pc_wr_val = start_pc;
		next_cycle();
		i_dbg_pc_wr_en = 1'b0;
		i_run = 1'b1;
		do
			next_cycle();
		while (!o_stopped);
		// a halted core must stay off the instruction bus while run is still high
		fetched = fetch_count;
		repeat (3) next_cycle();
		check_word("fetches after HALT", 32'(fetch_count), 32'(fetched));
		i_run = 1'b0;
	endtask

	task automatic check_results(input string name);
		for (int r = 0; r < `CPU_NREGS; r++) begin
			next_cycle();
			i_dbg_reg_sel = REG_SEL_W'(r);
			#1;
			check_word($sformatf("%s r%0d", name, r), o_dbg_reg_val, ref_regs[r]);
		end
		check_word({name, " pc"}, o_dbg_pc, ref_pc);
		check_count++;
		if (log_st_addr.size() != ref_st_addr.size()) begin
			error_count++;
			$display("[ERROR] %0t: %s logged %0d stores, expected %0d", $time, name,
				log_st_addr.size(), ref_st_addr.size());
		end else begin
			for (int i = 0; i < ref_st_addr.size(); i++) begin
				check_word($sformatf("%s store %0d address", name, i), 32'(log_st_addr[i]),
					32'(ref_st_addr[i]));
				check_word($sformatf("%s store %0d data", name, i), log_st_val[i],
					ref_st_val[i]);
			end
		end
	endtask

	initial begin : watchdog
		cycle_count = 0;
		while (cycle_count < MAX_CYCLES) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
		$display("errors: %0d in %0d checks", error_count, check_count);
		$display("FAIL: see errors above");
		$finish;
	end

	initial begin : test_sequence
		i_rst_n = 1'b0;
		i_run = 1'b0;
		i_i_data = '0;
		i_i_ack = 1'b0;
		i_d_data = '0;
		i_d_ack = 1'b0;
		i_dbg_reg_sel = '0;
		i_dbg_reg_wr_en = 1'b0;
		i_dbg_reg_wr_val = '0;
		i_dbg_pc_wr_en = 1'b0;
		i_dbg_pc_wr_val = '0;
		error_count = 0;
		check_count = 0;
		fetch_count = 0;
		load_programs();
		repeat (3) @(posedge clk);
		#2;
		i_rst_n = 1'b1;

		repeat (4) next_cycle();
		check_word("o_stopped with run low", {31'd0, o_stopped}, 32'd1);
		check_word("fetches with run low", 32'(fetch_count), 32'd0);

		run_program(32'h0000_0000);
		check_results("ALU chain");
		run_program(32'h0000_0080);
		check_results("store and load");
		run_program(32'h0000_0100);
		check_results("branch loop");
		debug_write(11, 32'h0000_55aa);
		debug_write(12, 32'h0000_0100);
		debug_write(0, 32'h0000_0077);
		run_program(32'h0000_0180);
		check_results("debug start");
		run_program(32'h0000_0200);
		check_results("random program");

		$display("errors: %0d in %0d checks", error_count, check_count);
		if (error_count == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

`default_nettype wire
